//--- common/fcmpPkg.sv
package fcmpPkg;

  // ####################
  // Sizes
  // ####################

  localparam int OpW     = 80;    // Operand bus
  localparam int FlagW   = 4;
  localparam int MaskW   = 2;     // One bit per single element
  localparam int TagW    = 3;
  localparam int Entries = 8;     // Flag file depth
  localparam int ExpW    = 16;    // Widened exponent
  localparam int FracW   = 64;    // Widened fraction
  localparam int Lanes   = 2;

  // ####################
  // Flag bit positions
  // ####################

  localparam int FlagC = 3;       // Carry, set on less or unordered
  localparam int FlagS = 2;
  localparam int FlagZ = 1;
  localparam int FlagU = 0;       // Unordered

  // Exponent field masks after right alignment
  localparam logic [ExpW-1:0] ExpMskSng = 16'h00ff;
  localparam logic [ExpW-1:0] ExpMskDbl = 16'h07ff;
  localparam logic [ExpW-1:0] ExpMskExt = 16'h7fff;

  // ####################
  // Encodings
  // ####################

  typedef enum logic [1:0] {
    fmtSng  = 2'd0,
    fmtDbl  = 2'd1,
    fmtExt  = 2'd2,
    fmtPair = 2'd3               // Two singles in bits 63..0
  } fmtE;

  typedef enum logic [1:0] {
    cmLess    = 2'd0,
    cmNotLess = 2'd1,
    cmEq      = 2'd2,
    cmNotEq   = 2'd3
  } cmodE;

endpackage

//--- fcmp/fcmpUnpack.sv
`timescale 1ns/1ps

module fcmpUnpack import fcmpPkg::*; (
  input  logic [OpW-1:0]   op,
  input  fmtE              fmt,
  input  logic             hi,      // Upper element of a pair
  output logic             sign,
  output logic [ExpW-1:0]  expo,
  output logic [FracW-1:0] frac,
  output logic             isZero,
  output logic             isInf,
  output logic             isNan
);

  logic [31:0]     word;            // Selected single element
  logic [ExpW-1:0] emsk;
  logic            tailNz;          // Fraction below the integer bit

  assign word = (fmt == fmtPair && hi) ? op[63:32] : op[31:0];

  // ####################
  // Field extraction
  // ####################

  // Exponent right aligned, fraction left aligned with the leading bit at 63,
  // so a single magnitude compare covers every format
  always_comb begin
    case (fmt)
      fmtExt: begin
        sign   = op[79];
        expo   = {1'b0, op[78:64]};
        frac   = op[63:0];              // Explicit integer bit
        emsk   = ExpMskExt;
        tailNz = |op[62:0];
      end
      fmtDbl: begin
        sign   = op[63];
        expo   = {5'b0, op[62:52]};
        frac   = {1'b1, op[51:0], 11'b0}; // Hidden bit
        emsk   = ExpMskDbl;
        tailNz = |op[51:0];
      end
      default: begin                    // Single and paired single
        sign   = word[31];
        expo   = {8'b0, word[30:23]};
        frac   = {1'b1, word[22:0], 40'b0};
        emsk   = ExpMskSng;
        tailNz = |word[22:0];
      end
    endcase
  end

  // ####################
  // Classes
  // ####################

  assign isZero = (expo == '0);            // Denormals fold to zero
  assign isInf  = (expo == emsk) && !tailNz;
  assign isNan  = (expo == emsk) && tailNz;

endmodule

//--- fcmp/fcmpCore.sv
`timescale 1ns/1ps

module fcmpCore import fcmpPkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             issueValid,
  input  fmtE              fmt,
  input  cmodE             cmod,
  input  logic [TagW-1:0]  tag,
  input  logic [OpW-1:0]   A,
  input  logic [OpW-1:0]   B,
  input  logic             grant,
  output logic             laneReady,
  output logic             req,
  output logic [TagW-1:0]  resTag,
  output logic [FlagW-1:0] resFlags,
  output logic [MaskW-1:0] resMask
);

  logic             sA0, sB0, sA1, sB1;
  logic [ExpW-1:0]  eA0, eB0, eA1, eB1;
  logic [FracW-1:0] fA0, fB0, fA1, fB1;
  logic             zA0, zB0, zA1, zB1;
  logic             iA0, iB0, iA1, iB1;
  logic             nA0, nB0, nA1, nB1;
  logic [FlagW-1:0] flags0, flags1;
  logic             m0, m1;
  logic             accept;

  // ####################
  // Element unpack
  // ####################

  fcmpUnpack u_unpackA0 (.op(A), .fmt(fmt), .hi(1'b0), .sign(sA0), .expo(eA0), .frac(fA0),
    .isZero(zA0), .isInf(iA0), .isNan(nA0));
  fcmpUnpack u_unpackB0 (.op(B), .fmt(fmt), .hi(1'b0), .sign(sB0), .expo(eB0), .frac(fB0),
    .isZero(zB0), .isInf(iB0), .isNan(nB0));
  fcmpUnpack u_unpackA1 (.op(A), .fmt(fmt), .hi(1'b1), .sign(sA1), .expo(eA1), .frac(fA1),
    .isZero(zA1), .isInf(iA1), .isNan(nA1));
  fcmpUnpack u_unpackB1 (.op(B), .fmt(fmt), .hi(1'b1), .sign(sB1), .expo(eB1), .frac(fB1),
    .isZero(zB1), .isInf(iB1), .isNan(nB1));

  // ####################
  // Compare
  // ####################

  function automatic logic [FlagW-1:0] cmpFlags(
    input logic                  sA,
    input logic [ExpW+FracW-1:0] mA,
    input logic                  zA,
    input logic                  iA,
    input logic                  nA,
    input logic                  sB,
    input logic [ExpW+FracW-1:0] mB,
    input logic                  zB,
    input logic                  iB,
    input logic                  nB
  );
    logic             magLt;
    logic             magEq;
    logic             lt;
    logic             eq;
    logic [FlagW-1:0] f;
    magLt = (mA < mB) && !(iA && iB);
    magEq = (mA == mB) || (iA && iB);   // Integer bit of an infinity ignored
    if (zA && zB) begin                 // Signed zeros are equal
      lt = 1'b0;
      eq = 1'b1;
    end else if (sA != sB) begin
      lt = sA;
      eq = 1'b0;
    end else begin
      eq = magEq;
      lt = sA ? (!magLt && !magEq) : magLt; // Order flips for negatives
    end
    f = '0;
    if (nA || nB) begin
      f[FlagU] = 1'b1;
      f[FlagC] = 1'b1;
    end else begin
      f[FlagC] = lt;
      f[FlagS] = lt;
      f[FlagZ] = eq;
    end
    return f;
  endfunction

  function automatic logic applyCmod(input cmodE cm, input logic [FlagW-1:0] f);
    case (cm)
      cmLess:    return f[FlagC];
      cmNotLess: return !f[FlagC];
      cmEq:      return f[FlagZ];
      cmNotEq:   return !f[FlagZ];
    endcase
  endfunction

  assign flags0 = cmpFlags(sA0, {eA0, fA0}, zA0, iA0, nA0, sB0, {eB0, fB0}, zB0, iB0, nB0);
  assign flags1 = cmpFlags(sA1, {eA1, fA1}, zA1, iA1, nA1, sB1, {eB1, fB1}, zB1, iB1, nB1);

  assign m0 = applyCmod(cmod, flags0);
  assign m1 = (fmt == fmtPair) ? applyCmod(cmod, flags1) : m0;

  // ####################
  // Result hold
  // ####################

  assign accept    = issueValid && laneReady;
  assign laneReady = !req;

  always_ff @(posedge clk) begin
    if (rst) begin
      req <= 1'b0;
    end else if (accept) begin
      req <= 1'b1;
    end else if (grant) begin
      req <= 1'b0;                      // Written this edge
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      resTag   <= tag;
      resFlags <= flags0;               // Lane 0 for pairs
      resMask  <= {m1, m0};
    end
  end

endmodule

//--- rtl/resultArbiter.sv
`timescale 1ns/1ps

module resultArbiter import fcmpPkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [Lanes-1:0] req,
  output logic [Lanes-1:0] grant
);

  logic last;                           // Winner of the last contest
  logic contest;

  assign contest = &req;

  // ####################
  // Grant
  // ####################

  always_comb begin
    case (req)
      2'b01:   grant = 2'b01;
      2'b10:   grant = 2'b10;
      2'b11:   grant = last ? 2'b01 : 2'b10; // Loser of last time wins
      default: grant = 2'b00;
    endcase
  end

  // ####################
  // Pointer
  // ####################

  // Lane 0 takes the first contest after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      last <= 1'b1;
    end else if (contest) begin
      last <= !last;
    end
  end

endmodule

//--- rtl/flagFile.sv
`timescale 1ns/1ps

module flagFile import fcmpPkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             wrEn,
  input  logic [TagW-1:0]  wrTag,
  input  logic [FlagW-1:0] wrFlags,
  input  logic [MaskW-1:0] wrMask,
  input  logic [TagW-1:0]  rdAddr,
  output logic [FlagW-1:0] rdFlags,
  output logic [MaskW-1:0] rdMask,
  output logic             rdValid
);

  logic [FlagW-1:0]   flagMem [Entries];
  logic [MaskW-1:0]   maskMem [Entries];
  logic [Entries-1:0] valid;

  // ####################
  // Write port
  // ####################

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (wrEn) begin
      valid[wrTag] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      flagMem[wrTag] <= wrFlags;
      maskMem[wrTag] <= wrMask;
    end
  end

  // ####################
  // Read port
  // ####################

  // Combinational, entry content is don't care while not valid
  assign rdFlags = flagMem[rdAddr];
  assign rdMask  = maskMem[rdAddr];
  assign rdValid = valid[rdAddr];

endmodule

//--- rtl/fcmpTop.sv
`timescale 1ns/1ps

module fcmpTop import fcmpPkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             issueValid0,
  input  fmtE              fmt0,
  input  cmodE             cmod0,
  input  logic [TagW-1:0]  tag0,
  input  logic [OpW-1:0]   A0,
  input  logic [OpW-1:0]   B0,
  output logic             laneReady0,
  input  logic             issueValid1,
  input  fmtE              fmt1,
  input  cmodE             cmod1,
  input  logic [TagW-1:0]  tag1,
  input  logic [OpW-1:0]   A1,
  input  logic [OpW-1:0]   B1,
  output logic             laneReady1,
  input  logic [TagW-1:0]  rdAddr,
  output logic [FlagW-1:0] rdFlags,
  output logic [MaskW-1:0] rdMask,
  output logic             rdValid
);

  logic [Lanes-1:0] req;
  logic [Lanes-1:0] grant;
  logic [TagW-1:0]  resTag   [Lanes];
  logic [FlagW-1:0] resFlags [Lanes];
  logic [MaskW-1:0] resMask  [Lanes];

  fcmpCore u_core0 (.clk(clk), .rst(rst), .issueValid(issueValid0), .fmt(fmt0), .cmod(cmod0),
    .tag(tag0), .A(A0), .B(B0), .grant(grant[0]), .laneReady(laneReady0), .req(req[0]),
    .resTag(resTag[0]), .resFlags(resFlags[0]), .resMask(resMask[0]));

  fcmpCore u_core1 (.clk(clk), .rst(rst), .issueValid(issueValid1), .fmt(fmt1), .cmod(cmod1),
    .tag(tag1), .A(A1), .B(B1), .grant(grant[1]), .laneReady(laneReady1), .req(req[1]),
    .resTag(resTag[1]), .resFlags(resFlags[1]), .resMask(resMask[1]));

  resultArbiter u_arb (.clk(clk), .rst(rst), .req(req), .grant(grant));

  // ####################
  // Write port mux
  // ####################

  logic             wrEn;
  logic [TagW-1:0]  wrTag;
  logic [FlagW-1:0] wrFlags;
  logic [MaskW-1:0] wrMask;

  assign wrEn    = |grant;
  assign wrTag   = grant[1] ? resTag[1]   : resTag[0];   // Grant is one-hot
  assign wrFlags = grant[1] ? resFlags[1] : resFlags[0];
  assign wrMask  = grant[1] ? resMask[1]  : resMask[0];

  flagFile u_flags (.clk(clk), .rst(rst), .wrEn(wrEn), .wrTag(wrTag), .wrFlags(wrFlags),
    .wrMask(wrMask), .rdAddr(rdAddr), .rdFlags(rdFlags), .rdMask(rdMask), .rdValid(rdValid));

endmodule

//--- bench/fcmpTb_assertions.sv
`timescale 1ns/1ps

module fcmpTb_assertions import fcmpPkg::*; (
  input logic             clk, rst,
  input logic             issueValid0, issueValid1,
  input fmtE              fmt0, fmt1,
  input cmodE             cmod0, cmod1,
  input logic [TagW-1:0]  tag0, tag1,
  input logic [OpW-1:0]   A0, B0, A1, B1,
  input logic             laneReady0, laneReady1,
  input logic [TagW-1:0]  rdAddr,
  input logic [FlagW-1:0] rdFlags,
  input logic [MaskW-1:0] rdMask,
  input logic             rdValid
);

  int                 errCount = 0;
  logic [FlagW-1:0]   expFlags [Entries];
  logic [MaskW-1:0]   expMask  [Entries];
  logic [Entries-1:0] expSet;          // Tag written at least once

  // ####################
  // Reference model
  // ####################

  // Raw sign and magnitude bits, ordered the same way as the value
  function automatic void fields(input fmtE f, input logic hi, input logic [OpW-1:0] x,
      output logic s, output logic [78:0] m, output logic z, output logic nan);
    logic [31:0] w;
    w = (f == fmtPair && hi) ? x[63:32] : x[31:0];
    case (f)
      fmtExt: begin
        s   = x[79];
        m   = x[78:0];
        z   = x[78:64] == 15'h0;
        nan = &x[78:64] && x[62:0] != 63'h0;
        if (&x[78:64] && !nan) m[63] = 1'b0; // Integer bit of an infinity
      end
      fmtDbl: begin
        s   = x[63];
        m   = {16'h0, x[62:0]};
        z   = x[62:52] == 11'h0;
        nan = &x[62:52] && x[51:0] != 52'h0;
      end
      default: begin
        s   = w[31];
        m   = {48'h0, w[30:0]};
        z   = w[30:23] == 8'h0;
        nan = &w[30:23] && w[22:0] != 23'h0;
      end
    endcase
  endfunction

  function automatic logic [FlagW-1:0] refFlags(input fmtE f, input logic hi,
      input logic [OpW-1:0] a, input logic [OpW-1:0] b);
    logic             sa, za, na, sb, zb, nb;
    logic [78:0]      ma, mb;
    logic [FlagW-1:0] r;
    fields(f, hi, a, sa, ma, za, na);
    fields(f, hi, b, sb, mb, zb, nb);
    r = '0;
    if (na || nb) begin
      r[FlagU] = 1'b1;
      r[FlagC] = 1'b1;
    end else if (za && zb) begin
      r[FlagZ] = 1'b1;                  // +0 equals -0
    end else begin
      r[FlagZ] = (sa == sb) && (ma == mb);
      r[FlagC] = (sa != sb) ? sa : (sa ? ma > mb : ma < mb);
      r[FlagS] = r[FlagC];
    end
    return r;
  endfunction

  // Odd codes negate, upper code bit picks Z over C
  function automatic logic maskBit(input cmodE cm, input logic [FlagW-1:0] fl);
    return (cm[1] ? fl[FlagZ] : fl[FlagC]) ^ cm[0];
  endfunction

  function automatic logic [MaskW-1:0] refMask(input fmtE f, input cmodE cm,
      input logic [OpW-1:0] a, input logic [OpW-1:0] b);
    logic lo;
    lo = maskBit(cm, refFlags(f, 1'b0, a, b));
    return {(f == fmtPair) ? maskBit(cm, refFlags(f, 1'b1, a, b)) : lo, lo};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      expSet <= '0;
    end else begin
      if (issueValid0 && laneReady0) begin
        expFlags[tag0] <= refFlags(fmt0, 1'b0, A0, B0);
        expMask[tag0]  <= refMask(fmt0, cmod0, A0, B0);
        expSet[tag0]   <= 1'b1;
      end
      if (issueValid1 && laneReady1) begin
        expFlags[tag1] <= refFlags(fmt1, 1'b0, A1, B1);
        expMask[tag1]  <= refMask(fmt1, cmod1, A1, B1);
        expSet[tag1]   <= 1'b1;
      end
    end
  end

  // ####################
  // Checks
  // ####################

  assert property (@(posedge clk) rst |=> laneReady0 && laneReady1 && !rdValid)
    else begin
      errCount++;
      $error("Reset state wrong at %0t, a lane is busy or an entry is valid", $time);
    end

  // Flag file is settled whenever both lanes are idle
  assert property (@(posedge clk) disable iff (rst)
      laneReady0 && laneReady1 |-> rdValid == expSet[rdAddr])
    else begin
      errCount++;
      $error("Fail %0t rdValid exp=%b got=%b", $time, $sampled(expSet[rdAddr]),
        $sampled(rdValid));
    end

  assert property (@(posedge clk) disable iff (rst)
      laneReady0 && laneReady1 && expSet[rdAddr] |-> rdFlags == expFlags[rdAddr])
    else begin
      errCount++;
      $error("Fail %0t rdFlags exp=%h got=%h", $time, $sampled(expFlags[rdAddr]),
        $sampled(rdFlags));
    end

  assert property (@(posedge clk) disable iff (rst)
      laneReady0 && laneReady1 && expSet[rdAddr] |-> rdMask == expMask[rdAddr])
    else begin
      errCount++;
      $error("Fail %0t rdMask exp=%b got=%b", $time, $sampled(expMask[rdAddr]),
        $sampled(rdMask));
    end

  assert property (@(posedge clk) disable iff (rst) issueValid0 && laneReady0 |=> !laneReady0)
    else begin
      errCount++;
      $error("Fail %0t laneReady0 exp=0 got=%b", $time, $sampled(laneReady0));
    end

  assert property (@(posedge clk) disable iff (rst) issueValid1 && laneReady1 |=> !laneReady1)
    else begin
      errCount++;
      $error("Fail %0t laneReady1 exp=0 got=%b", $time, $sampled(laneReady1));
    end

  assert property (@(posedge clk) disable iff (rst)
      !laneReady0 && $past(!laneReady0) |=> laneReady0)
    else begin
      errCount++;
      $error("Fail %0t laneReady0 exp=1 got=%b", $time, $sampled(laneReady0));
    end

  assert property (@(posedge clk) disable iff (rst)
      !laneReady1 && $past(!laneReady1) |=> laneReady1)
    else begin
      errCount++;
      $error("Fail %0t laneReady1 exp=1 got=%b", $time, $sampled(laneReady1));
    end

endmodule

bind fcmpTop fcmpTb_assertions u_chk (.*);

//--- bench/fcmpTb.sv
`timescale 1ns/1ps

module fcmpTb import fcmpPkg::*; ();

  localparam int Rounds  = 12;
  localparam int CycleNs = 100;
  localparam int WatchNs = Rounds * 8 * 4 * CycleNs + 16 * CycleNs + 60000;

  logic             clk = 1'b0;
  logic             rst;
  logic             issueValid0, issueValid1;
  fmtE              fmt0, fmt1;
  cmodE             cmod0, cmod1;
  logic [TagW-1:0]  tag0, tag1;
  logic [OpW-1:0]   A0, B0, A1, B1;
  logic             laneReady0, laneReady1;
  logic [TagW-1:0]  rdAddr;
  logic [FlagW-1:0] rdFlags;
  logic [MaskW-1:0] rdMask;
  logic             rdValid;
  integer           seed = 32'hdbf;
  logic [TagW-1:0]  order [Entries];

  fcmpTop u_dut (.*);

  always #(CycleNs / 2) clk = ~clk;

  task automatic abortRun(input string why);
    $display("ERRORS FOUND");
    $fatal(1, "%s", why);
  endtask

  // ####################
  // Operands
  // ####################

  function automatic logic [OpW-1:0] applyClass(input logic [OpW-1:0] v,
      input logic [OpW-1:0] eM, input logic [OpW-1:0] fM, input logic [OpW-1:0] iM, input int k);
    case (k)
      0:       return v & ~(eM | fM);                 // Zero
      1:       return (v | eM | iM) & ~fM;            // Infinity
      2:       return v | eM | (fM & ~(fM << 1));     // NaN
      3:       return v & ~eM;                        // Denormal
      default: return v;
    endcase
  endfunction

  function automatic logic [OpW-1:0] randOp(input logic [OpW-1:0] eM, input logic [OpW-1:0] fM,
      input logic [OpW-1:0] iM, input logic pair);
    logic [OpW-1:0] v;
    v = {16'($random(seed)), $random(seed), $random(seed)};
    v = applyClass(v, eM, fM, iM, $unsigned($random(seed)) % 8);
    if (pair) v = applyClass(v, eM << 32, fM << 32, iM, $unsigned($random(seed)) % 8);
    return v;
  endfunction

  task automatic makeOperands(input fmtE f, output logic [OpW-1:0] a, output logic [OpW-1:0] b);
    logic [OpW-1:0] eM, fM, iM, sM;
    int             pick;
    iM = '0;
    case (f)
      fmtDbl: begin
        eM = {16'h0, 64'h7ff0_0000_0000_0000};
        fM = {28'h0, 52'hf_ffff_ffff_ffff};
        sM = 80'h1 << 63;
      end
      fmtExt: begin
        eM = {1'b0, 15'h7fff, 64'h0};
        fM = {17'h0, 63'h7fff_ffff_ffff_ffff};
        iM = 80'h1 << 63;                             // Explicit integer bit
        sM = 80'h1 << 79;
      end
      default: begin
        eM = 80'h7f80_0000;
        fM = 80'h7f_ffff;
        sM = 80'h8000_0000_8000_0000;
      end
    endcase
    a = randOp(eM, fM, iM, f == fmtPair);
    pick = $unsigned($random(seed)) % 5;
    if (pick == 0) begin
      b = a;                                          // Equal pair
    end else if (pick == 1) begin
      b = a ^ sM;                                     // Signs flipped
    end else if (pick == 2) begin
      a = applyClass(a, eM, fM, iM, 1) ^ iM;          // Infinity with the integer bit clear
      b = a ^ iM;                                     // Same infinity with the integer bit set
    end else begin
      b = randOp(eM, fM, iM, f == fmtPair);
    end
  endtask

  // ####################
  // Stimulus
  // ####################

  task automatic issueOps(input logic use0, input logic use1,
      input logic [TagW-1:0] t0, input logic [TagW-1:0] t1);
    fmtE            f;
    logic [OpW-1:0] a, b;
    logic           poke;
    @(negedge clk);
    while ((use0 && !laneReady0) || (use1 && !laneReady1)) @(negedge clk);
    poke = use0 && (($random(seed) & 3) == 0);
    @(posedge clk);
    if (use0) begin
      f = fmtE'(2'($random(seed)));
      makeOperands(f, a, b);
      fmt0        <= f;
      cmod0       <= cmodE'(2'($random(seed)));
      tag0        <= t0;
      A0          <= a;
      B0          <= b;
      issueValid0 <= 1'b1;
    end
    if (use1) begin
      f = fmtE'(2'($random(seed)));
      makeOperands(f, a, b);
      fmt1        <= f;
      cmod1       <= cmodE'(2'($random(seed)));
      tag1        <= t1;
      A1          <= a;
      B1          <= b;
      issueValid1 <= 1'b1;
    end
    @(posedge clk);
    issueValid1 <= 1'b0;
    issueValid0 <= poke;                              // Lane is busy so this is ignored
    A0          <= B0;
    B0          <= A0;
    if (poke) begin
      @(posedge clk);
      issueValid0 <= 1'b0;
    end
  endtask

  task automatic sweepReads();
    @(negedge clk);
    while (!(laneReady0 && laneReady1)) @(negedge clk);
    for (int a = 0; a < Entries; a++) begin
      @(posedge clk);
      rdAddr <= TagW'(a);
    end
    @(posedge clk);
  endtask

  initial begin
    int              i;
    int              j;
    int              mode;
    logic [TagW-1:0] tmp;
    rst         = 1'b1;
    issueValid0 = 1'b0;
    issueValid1 = 1'b0;
    fmt0        = fmtSng;
    fmt1        = fmtSng;
    cmod0       = cmLess;
    cmod1       = cmLess;
    tag0        = '0;
    tag1        = '0;
    A0          = '0;
    B0          = '0;
    A1          = '0;
    B1          = '0;
    rdAddr      = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    sweepReads();
    for (int r = 0; r < Rounds; r++) begin
      for (int t = 0; t < Entries; t++) order[t] = TagW'(t);
      for (int t = Entries - 1; t > 0; t--) begin   // Shuffle tags
        j = $unsigned($random(seed)) % (t + 1);
        tmp      = order[t];
        order[t] = order[j];
        order[j] = tmp;
      end
      i = 0;
      while (i < Entries) begin
        mode = $unsigned($random(seed)) % 3;
        if (mode == 0 && i < Entries - 1) begin
          issueOps(1'b1, 1'b1, order[i], order[i+1]);
          i += 2;
        end else if (mode == 1) begin
          issueOps(1'b1, 1'b0, order[i], '0);
          i++;
        end else begin
          issueOps(1'b0, 1'b1, '0, order[i]);
          i++;
        end
      end
      sweepReads();
    end
    @(posedge clk);
    #(CycleNs / 4);
    if (u_dut.u_chk.errCount != 0) begin
      abortRun("Assertion failures were counted during the run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  initial begin
    while (u_dut.u_chk.errCount == 0) @(negedge clk);
    abortRun("A checker assertion failed");
  end

  initial begin
    #(WatchNs);
    abortRun("Watchdog expired before the test sequence finished");
  end

endmodule

//--- vlog.f
common/fcmpPkg.sv
fcmp/fcmpUnpack.sv
fcmp/fcmpCore.sv
rtl/resultArbiter.sv
rtl/flagFile.sv
rtl/fcmpTop.sv
bench/fcmpTb_assertions.sv
bench/fcmpTb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = fcmpTb
FLIST = vlog.f
LOG   = sim.log
SRCS  = $(shell grep -v '^+' $(FLIST))
BIN   = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	-./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
